// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -sv -Wno-fatal -j 0 --top-module coreTb -f vlog.f

run: build
	./obj_dir/VcoreTb | tee /dev/stderr | grep -q "Test passed"

lint:
	verilator --lint-only --timing -sv -Wall --top-module coreTb -f vlog.f

clean:
	rm -rf obj_dir

// ==== logic/femtoCore.sv ====
// femtoCore top level, connects decoder, registers, ALU, load/store and FSM
`timescale 1ns/1ps
`default_nettype none

module femtoCore #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int          addrWidth = 24
) (
   input  logic          clk,
   input  logic          reset,
   output rvPkg::memReqT memReq,
   input  logic [31:0]   memRdata,
   input  logic          memRbusy,
   input  logic          memWbusy,
   output logic          halt
);
   import rvPkg::*;

   decodedT              dec;
   logic [xlen-1:0]      rs1;
   logic [xlen-1:0]      rs2;
   logic [xlen-1:0]      aluOut;
   logic [xlen-1:0]      aluSum;
   logic                 takeBranch;
   logic [addrWidth-1:0] lsAddr;
   logic [xlen-1:0]      loadData;
   logic [xlen-1:0]      storeData;
   logic [3:0]           storeMask;
   logic                 instrLatch;
   logic                 writeEn;
   logic [xlen-1:0]      writeData;
   logic [xlen-1:0]      memAddr;
   logic [3:0]           memWmask;
   logic                 memRstrb;
   logic                 memAccess;

   rvDecoder i_decoder (
      .clk        (clk),
      .reset      (reset),
      .instrLatch (instrLatch),
      .memRdata   (memRdata),
      .dec        (dec)
   );

   rvRegFile i_regFile (
      .clk        (clk),
      .instrLatch (instrLatch),
      .memRdata   (memRdata),
      .writeEn    (writeEn),
      .rdId       (dec.rdId),
      .writeData  (writeData),
      .rs1        (rs1),
      .rs2        (rs2)
   );

   rvAlu i_alu (
      .dec        (dec),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluOut     (aluOut),
      .aluSum     (aluSum),
      .takeBranch (takeBranch)
   );

   rvLoadStore #(
      .addrWidth (addrWidth)
   ) i_loadStore (
      .dec       (dec),
      .rs1       (rs1),
      .rs2       (rs2),
      .memRdata  (memRdata),
      .lsAddr    (lsAddr),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask)
   );

   rvControl #(
      .addrWidth (addrWidth),
      .resetAddr (resetAddr)
   ) i_control (
      .clk        (clk),
      .reset      (reset),
      .dec        (dec),
      .aluOut     (aluOut),
      .aluSum     (aluSum),
      .takeBranch (takeBranch),
      .lsAddr     (lsAddr),
      .loadData   (loadData),
      .storeMask  (storeMask),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .instrLatch (instrLatch),
      .writeEn    (writeEn),
      .writeData  (writeData),
      .memAddr    (memAddr),
      .memWmask   (memWmask),
      .memRstrb   (memRstrb),
      .memAccess  (memAccess),
      .halt       (halt)
   );

   // Bundle the bus signals for the memory side
   assign memReq = '{addr: memAddr, wdata: storeData, wmask: memWmask,
                     rstrb: memRstrb, access: memAccess};

endmodule

`default_nettype wire

// ==== logic/rvAlu.sv ====
// Integer ALU and branch predicate, fully combinational
`timescale 1ns/1ps
`default_nettype none

module rvAlu (
   input  rvPkg::decodedT dec,
   input  logic [31:0]    rs1,
   input  logic [31:0]    rs2,
   output logic [31:0]    aluOut,
   output logic [31:0]    aluSum,
   output logic           takeBranch
);
   import rvPkg::*;

   logic [xlen-1:0] aluIn2;
   logic [xlen:0]   aluMinus;
   logic            isEq;
   logic            isLt;
   logic            isLtu;
   logic [xlen-1:0] shiftIn;
   logic [4:0]      shiftAmt;
   logic            signFill;
   logic [xlen-1:0] shiftRight;
   logic [xlen-1:0] shiftLeft;
   logic            predicate;

   function automatic logic [31:0] reverseBits(input logic [31:0] value);
      logic [31:0] result;
      for (int i = 0; i < 32; i++) begin
         result[i] = value[31 - i];
      end
      return result;
   endfunction

   // Register form and branches compare rs2, everything else uses immI
   assign aluIn2 = (dec.opcode == opAluReg || dec.opcode == opBranch) ? rs2 : dec.immI;

   // Plain adder, also the JALR target
   assign aluSum = rs1 + aluIn2;

   // One subtractor for SUB and all three comparisons
   // Bit 32 is the borrow, set when rs1 is below aluIn2 unsigned
   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   assign isEq     = (aluMinus[xlen-1:0] == '0);
   assign isLtu    = aluMinus[xlen];
   // Signs differ, so the negative operand is the smaller one
   assign isLt     = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[xlen];

   // Left shifts run through the right shifter with reversed bits
   assign shiftIn  = (dec.funct3 == 3'b001) ? reverseBits(rs1) : rs1;
   assign shiftAmt = aluIn2[4:0];
   // Arithmetic fill only for SRA and SRAI
   assign signFill = dec.altBit & rs1[31] & (dec.funct3 == 3'b101);
   assign shiftRight = (shiftIn >> shiftAmt) |
                       ({xlen{signFill}} & ~({xlen{1'b1}} >> shiftAmt));
   assign shiftLeft  = reverseBits(shiftRight);

   always_comb begin
      case (dec.funct3)
         // SUB needs bit 30 and the register form, ADDI reuses bit 30 as immediate
         3'b000:  aluOut = (dec.altBit & dec.regOpBit) ? aluMinus[xlen-1:0] : aluSum;
         3'b001:  aluOut = shiftLeft;
         3'b010:  aluOut = {31'b0, isLt};
         3'b011:  aluOut = {31'b0, isLtu};
         3'b100:  aluOut = rs1 ^ aluIn2;
         3'b101:  aluOut = shiftRight;
         3'b110:  aluOut = rs1 | aluIn2;
         default: aluOut = rs1 & aluIn2;
      endcase
   end

   // Branch condition from funct3, 010 and 011 are not branches
   always_comb begin
      case (dec.funct3)
         3'b000:  predicate = isEq;
         3'b001:  predicate = !isEq;
         3'b100:  predicate = isLt;
         3'b101:  predicate = !isLt;
         3'b110:  predicate = isLtu;
         3'b111:  predicate = !isLtu;
         default: predicate = 1'b0;
      endcase
   end

   assign takeBranch = (dec.opcode == opBranch) & predicate;

endmodule

`default_nettype wire

// ==== logic/rvControl.sv ====
// Fetch/execute FSM, program counter, write-back select and memory strobes
`timescale 1ns/1ps
`default_nettype none

module rvControl #(
   parameter int          addrWidth = 24,
   parameter logic [31:0] resetAddr = 32'h0000_0000
) (
   input  logic                 clk,
   input  logic                 reset,
   input  rvPkg::decodedT       dec,
   input  logic [31:0]          aluOut,
   input  logic [31:0]          aluSum,
   input  logic                 takeBranch,
   input  logic [addrWidth-1:0] lsAddr,
   input  logic [31:0]          loadData,
   input  logic [3:0]           storeMask,
   input  logic                 memRbusy,
   input  logic                 memWbusy,
   output logic                 instrLatch,
   output logic                 writeEn,
   output logic [31:0]          writeData,
   output logic [31:0]          memAddr,
   output logic [3:0]           memWmask,
   output logic                 memRstrb,
   output logic                 memAccess,
   output logic                 halt
);
   import rvPkg::*;

   coreStateT            state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] nextPc;
   logic                 isLoad;
   logic                 isStore;
   logic                 isExec;
   logic                 fetchPhase;

   assign isLoad     = (dec.opcode == opLoad);
   assign isStore    = (dec.opcode == opStore);
   assign isExec     = (state == stExecute);
   assign fetchPhase = (state == stFetch) || (state == stWaitInstr);

   // JAL and branch targets share one adder
   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = pc + ((dec.opcode == opJal) ? dec.immJ[addrWidth-1:0]
                                                  : dec.immB[addrWidth-1:0]);
   // JALR clears bit 0 of the target
   assign nextPc = (dec.opcode == opJalr) ? {aluSum[addrWidth-1:1], 1'b0} :
                   (dec.opcode == opJal || takeBranch) ? pcPlusImm : pcPlus4;

   always_comb begin
      case (dec.opcode)
         opLui:              writeData = dec.immU;
         // AUIPC works on the full 32 bits
         opAuipc:            writeData = 32'(pc) + dec.immU;
         opAluImm, opAluReg: writeData = aluOut;
         opJal, opJalr:      writeData = 32'(pcPlus4);
         opLoad:             writeData = loadData;
         default:            writeData = '0;
      endcase
   end

   // Loads keep writing in the wait state until the data has settled
   assign writeEn = !(dec.opcode == opBranch || isStore || dec.opcode == opSystem) &&
                    (isExec || state == stWaitMem);

   // Instruction word and operands are captured together
   assign instrLatch = (state == stWaitInstr) && !memRbusy;

   assign memAddr   = fetchPhase ? 32'(pc) : 32'(lsAddr);
   assign memRstrb  = (state == stFetch) || (isExec && isLoad);
   assign memWmask  = {4{isExec && isStore}} & storeMask;
   assign memAccess = fetchPhase || ((isExec || state == stWaitMem) && (isLoad || isStore));
   assign halt      = (state == stHalt);

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Wait for the memory to go idle before the first fetch
         state <= stWaitMem;
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         case (state)
            stFetch: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) begin
                  state <= stExecute;
               end
            end
            stExecute: begin
               pc <= nextPc;
               if (dec.isEbreak) begin
                  state <= stHalt;
               end else if (isLoad || isStore) begin
                  state <= stWaitMem;
               end else begin
                  state <= stFetch;
               end
            end
            stWaitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= stFetch;
               end
            end
            // Stuck until reset
            stHalt:  state <= stHalt;
            default: state <= stWaitMem;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/rvDecoder.sv ====
// Instruction register and field decoding, feeds the decoded bundle to the core
`timescale 1ns/1ps
`default_nettype none

module rvDecoder (
   input  logic           clk,
   input  logic           reset,
   input  logic           instrLatch,
   input  logic [31:0]    memRdata,
   output rvPkg::decodedT dec
);
   import rvPkg::*;

   // ADDI x0, x0, 0 without its two low bits
   localparam logic [31:2] nopInstr = 30'h0000_0004;

   // Bits 1:0 are always 11 in RV32I, so they are not kept
   logic [31:2] instrReg;

   // Reset to a NOP so that rd is x0 while the FSM sits in its wait state
   always_ff @(posedge clk) begin
      if (!reset) begin
         instrReg <= nopInstr;
      end else if (instrLatch) begin
         instrReg <= memRdata[31:2];
      end
   end

   always_comb begin
      // Opcode bits map straight onto the enum
      dec.opcode   = opcodeT'(instrReg[6:2]);
      dec.funct3   = instrReg[14:12];
      dec.altBit   = instrReg[30];
      dec.regOpBit = instrReg[5];
      dec.rdId     = instrReg[11:7];

      // Sign-extended immediate formats
      dec.immI = {{21{instrReg[31]}}, instrReg[30:20]};
      dec.immS = {{21{instrReg[31]}}, instrReg[30:25], instrReg[11:7]};
      // Branch offset, halfword aligned
      dec.immB = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                  instrReg[11:8], 1'b0};
      // Upper immediate, low 12 bits cleared
      dec.immU = {instrReg[31:12], 12'b0};
      // Jump offset, halfword aligned
      dec.immJ = {{12{instrReg[31]}}, instrReg[19:12], instrReg[20],
                  instrReg[30:21], 1'b0};

      // EBREAK is SYSTEM with funct3 0 and immediate 1
      // ECALL and CSR accesses fall through as no-ops
      dec.isEbreak = (instrReg[6:2] == opSystem) &&
                     (instrReg[14:12] == 3'b000) &&
                     (instrReg[31:20] == 12'h001);
   end

endmodule

`default_nettype wire

// ==== logic/rvLoadStore.sv ====
// Load/store address, load lane extraction and store lane steering
`timescale 1ns/1ps
`default_nettype none

module rvLoadStore #(
   parameter int addrWidth = 24
) (
   input  rvPkg::decodedT       dec,
   input  logic [31:0]          rs1,
   input  logic [31:0]          rs2,
   input  logic [31:0]          memRdata,
   output logic [addrWidth-1:0] lsAddr,
   output logic [31:0]          loadData,
   output logic [31:0]          storeData,
   output logic [3:0]           storeMask
);
   import rvPkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // funct3 bits 1:0 give the size, 00 byte, 01 halfword, 10 word
   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   // Stores take immS, loads take immI
   assign lsAddr = rs1[addrWidth-1:0] +
                   ((dec.opcode == opStore) ? dec.immS[addrWidth-1:0]
                                            : dec.immI[addrWidth-1:0]);

   // Pick the addressed halfword, then the byte inside it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3 bit 2 set means LBU or LHU
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   always_comb begin
      if (byteAccess) begin
         loadData = {{24{loadSign}}, loadByte};
      end else if (halfAccess) begin
         loadData = {{16{loadSign}}, loadHalf};
      end else begin
         loadData = memRdata;
      end
   end

   // Low byte and low halfword copied so every lane holds the right value
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2[7:0] :
                             lsAddr[1] ? rs2[15:8] : rs2[31:24];

   // One lane for bytes, two for halfwords, all four for words
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

// ==== logic/rvPkg.sv ====
// Shared widths, enums and bundles for the femtoCore RTL and its testbench
`default_nettype none

package rvPkg;

   // Data path and register index widths
   localparam int xlen = 32;
   localparam int regIdW = 5;

   // Major opcodes, taken from instruction bits 6:2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011,
      opSystem = 5'b11100
   } opcodeT;

   // Core FSM states, one-hot
   typedef enum logic [4:0] {
      stFetch     = 5'b00001,
      stWaitInstr = 5'b00010,
      stExecute   = 5'b00100,
      stWaitMem   = 5'b01000,
      stHalt      = 5'b10000
   } coreStateT;

   // Decoded instruction, shared by every block of the core
   typedef struct packed {
      opcodeT              opcode;
      logic [2:0]          funct3;
      // Bit 30, SUB versus ADD and SRA versus SRL
      logic                altBit;
      // Bit 5, register form versus immediate form
      logic                regOpBit;
      logic [regIdW-1:0]   rdId;
      logic [xlen-1:0]     immI;
      logic [xlen-1:0]     immS;
      logic [xlen-1:0]     immB;
      logic [xlen-1:0]     immU;
      logic [xlen-1:0]     immJ;
      logic                isEbreak;
   } decodedT;

   // Memory request leaving the core
   typedef struct packed {
      logic [xlen-1:0]     addr;
      logic [xlen-1:0]     wdata;
      // Byte lanes to write, zero for no write
      logic [3:0]          wmask;
      // One-cycle read strobe
      logic                rstrb;
      // Fetch or data access in progress
      logic                access;
   } memReqT;

endpackage

`default_nettype wire

// ==== logic/rvRegFile.sv ====
// General register file with x0 tied to zero, source operands latched at fetch
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
   input  logic        clk,
   input  logic        instrLatch,
   input  logic [31:0] memRdata,
   input  logic        writeEn,
   input  logic [4:0]  rdId,
   input  logic [31:0] writeData,
   output logic [31:0] rs1,
   output logic [31:0] rs2
);
   import rvPkg::*;

   // x1 to x31, x0 has no storage
   logic [xlen-1:0]   regs [1:31];
   logic [regIdW-1:0] rs1Id;
   logic [regIdW-1:0] rs2Id;

   // Source indices come from the raw fetched word
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   always_ff @(posedge clk) begin
      // Writes to x0 are dropped
      if (writeEn && rdId != '0) begin
         regs[rdId] <= writeData;
      end
      // Operands are read in the same cycle the instruction is latched
      if (instrLatch) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

   // Destination index must be defined whenever the FSM writes back
   assert property (@(posedge clk) writeEn |-> !$isunknown(rdId))
      else $error("register write with unknown destination");

endmodule

`default_nettype wire

// ==== testbench/coreTb.sv ====
// Top-level testbench for femtoCore, checks the store sequence and the halt behavior
`timescale 1ns/1ps
`default_nettype none

module coreTb;
   import rvPkg::*;

   localparam logic [31:0] resetAddr = 32'h0000_0000;
   localparam int          clkPeriod = 20;
   localparam int          maxCycles = 20000;

   logic        clk;
   logic        reset;
   memReqT      memReq;
   logic [31:0] memRdata;
   logic        memRbusy;
   logic        memWbusy;
   logic        halt;
   logic        storeSeen;
   logic [31:0] storeAddr;
   logic [3:0]  storeMask;
   logic [31:0] storeData;

   logic [31:0] expAddr [$];
   logic [3:0]  expMask [$];
   logic [31:0] expData [$];
   int          storeIdx;
   logic        firstFetchSeen;
   logic [31:0] lanes;

   femtoCore #(
      .resetAddr (resetAddr),
      .addrWidth (24)
   ) i_dut (
      .clk      (clk),
      .reset    (reset),
      .memReq   (memReq),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy),
      .halt     (halt)
   );

   tbMemory i_memory (
      .clk       (clk),
      .reset     (reset),
      .memReq    (memReq),
      .memRdata  (memRdata),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .storeSeen (storeSeen),
      .storeAddr (storeAddr),
      .storeMask (storeMask),
      .storeData (storeData)
   );

   task automatic valueMismatch(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic addExpect(input logic [31:0] addr, input logic [3:0] mask,
                            input logic [31:0] data);
      expAddr.push_back(addr);
      expMask.push_back(mask);
      expData.push_back(data);
   endtask

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Watchdog over the whole run
   initial begin
      #(maxCycles * clkPeriod);
      abortRun("Timeout: the core did not halt within the cycle limit");
   end

   // Store checks, in program order
   always @(posedge clk) begin
      if (storeSeen) begin
         if (storeIdx >= expAddr.size()) begin
            abortRun($sformatf("Unexpected store to 0x%08h after the last expected one",
                               storeAddr));
         end else begin
            lanes = {{8{storeMask[3]}}, {8{storeMask[2]}}, {8{storeMask[1]}},
                     {8{storeMask[0]}}};
            assert ({storeAddr[31:2], 2'b00} == expAddr[storeIdx])
               else valueMismatch($sformatf("store %0d address 0x%08h, expected 0x%08h",
                                            storeIdx, storeAddr, expAddr[storeIdx]));
            assert (storeMask == expMask[storeIdx])
               else valueMismatch($sformatf("store %0d mask %b, expected %b",
                                            storeIdx, storeMask, expMask[storeIdx]));
            assert ((storeData & lanes) == expData[storeIdx])
               else valueMismatch($sformatf("store %0d data 0x%08h, expected 0x%08h",
                                            storeIdx, storeData & lanes, expData[storeIdx]));
            storeIdx <= storeIdx + 1;
         end
      end
   end

   // Bus checks on the stable half of the cycle
   always @(negedge clk) begin
      if (reset && memReq.rstrb && !firstFetchSeen) begin
         firstFetchSeen <= 1'b1;
         assert (memReq.addr == resetAddr)
            else valueMismatch($sformatf("first fetch at 0x%08h", memReq.addr));
      end
      // Every strobe and every write belongs to a flagged access
      if (reset && (memReq.rstrb || memReq.wmask != 4'b0000)) begin
         assert (memReq.access)
            else valueMismatch("read strobe or write mask without the access flag");
      end
      if (reset && halt) begin
         assert (!memReq.rstrb && memReq.wmask == 4'b0000 && !memReq.access)
            else valueMismatch("memory request while halted");
      end
   end

   initial begin
      reset          = 1'b0;
      storeIdx       = 0;
      firstFetchSeen = 1'b0;
      // ALU results
      addExpect(32'h200, 4'hf, 32'hffff_fff4);
      addExpect(32'h204, 4'hf, 32'h0000_0001);
      addExpect(32'h208, 4'hf, 32'h0000_0000);
      addExpect(32'h20c, 4'hf, 32'hffff_fffc);
      addExpect(32'h210, 4'hf, 32'hffff_ffff);
      addExpect(32'h214, 4'hf, 32'h0000_0003);
      addExpect(32'h218, 4'hf, 32'h8000_0000);
      addExpect(32'h21c, 4'hf, 32'h0000_0001);
      addExpect(32'h220, 4'hf, 32'hffff_ffff);
      addExpect(32'h224, 4'hf, 32'hffff_fffb);
      addExpect(32'h228, 4'hf, 32'h1234_5000);
      addExpect(32'h22c, 4'hf, 32'h0000_1068);
      // Byte and halfword lanes
      addExpect(32'h230, 4'b0001, 32'h0000_00d4);
      addExpect(32'h230, 4'b0010, 32'h0000_d400);
      addExpect(32'h230, 4'b0100, 32'h00d4_0000);
      addExpect(32'h230, 4'b1000, 32'hd400_0000);
      addExpect(32'h234, 4'b0011, 32'h0000_c3d4);
      addExpect(32'h234, 4'b1100, 32'hc3d4_0000);
      addExpect(32'h238, 4'hf, 32'ha1b2_c3d4);
      // Loads with extension
      addExpect(32'h23c, 4'hf, 32'hffff_ffd4);
      addExpect(32'h240, 4'hf, 32'h0000_00c3);
      addExpect(32'h244, 4'hf, 32'hffff_a1b2);
      addExpect(32'h248, 4'hf, 32'h0000_c3d4);
      addExpect(32'h24c, 4'hf, 32'ha1b2_c3d4);
      // Six not-taken branches, then the JAL and JALR links
      addExpect(32'h250, 4'hf, 32'h0000_0006);
      addExpect(32'h254, 4'hf, 32'h0000_0128);
      addExpect(32'h258, 4'hf, 32'h0000_0138);

      repeat (16) @(negedge clk);
      reset = 1'b1;
      assert (!memReq.rstrb && memReq.wmask == 4'b0000 && !halt)
         else valueMismatch("bus not idle when reset is released");

      wait (halt == 1'b1);
      assert (storeIdx == expAddr.size())
         else valueMismatch($sformatf("halt after %0d stores, expected %0d",
                                      storeIdx, expAddr.size()));
      // Stay a while in the halted state for the bus checks
      repeat (20) @(negedge clk);
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/tbMemory.sv ====
// Word memory model for the core testbench, holds the test program and reports each store
`timescale 1ns/1ps
`default_nettype none

module tbMemory (
   input  logic          clk,
   input  logic          reset,
   input  rvPkg::memReqT memReq,
   output logic [31:0]   memRdata,
   output logic          memRbusy,
   output logic          memWbusy,
   output logic          storeSeen,
   output logic [31:0]   storeAddr,
   output logic [3:0]    storeMask,
   output logic [31:0]   storeData
);
   import rvPkg::*;

   localparam logic [6:0] opOp    = 7'b0110011;
   localparam logic [6:0] opImm   = 7'b0010011;
   localparam logic [6:0] opLd    = 7'b0000011;
   localparam logic [6:0] opLuiC  = 7'b0110111;
   localparam logic [6:0] opAuiC  = 7'b0010111;
   localparam logic [6:0] opJalrC = 7'b1100111;
   localparam logic [6:0] alt     = 7'b0100000;

   logic [31:0] mem [0:255];
   int          loadIdx;
   int          rCount;
   int          wCount;
   integer      seed;

   // Instruction formats, assembled field by field
   function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opOp};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] op);
      return {imm, 5'(rs1), f3, 5'(rd), op};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
      return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
      return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
   endfunction

   task automatic emit(input logic [31:0] word);
      mem[loadIdx] = word;
      loadIdx++;
   endtask

   // One branch pair: taken skips a poison store, not taken runs the counter increment
   task automatic branchPair(input int rs1, input int rs2, input logic [2:0] f3,
                             input logic taken);
      emit(encB(13'd8, rs2, rs1, f3));
      if (taken) begin
         emit(encS(12'h1fc, 1, 10, 3'b010));
      end else begin
         emit(encI(12'd1, 23, 3'b000, 23, opImm));
      end
   endtask

   initial begin
      seed      = 48491;
      memRdata  = '0;
      memRbusy  = 1'b0;
      memWbusy  = 1'b0;
      storeSeen = 1'b0;
      storeAddr = '0;
      storeMask = '0;
      storeData = '0;
      rCount    = 0;
      wCount    = 0;
      // Background pattern, distinct for every word address
      for (int i = 0; i < 256; i++) begin
         mem[i] = 32'h5a5a_0000 ^ (i * 4);
      end
      loadIdx = 0;
      // Base pointer and signed operands
      emit(encI(12'd512, 0, 3'b000, 10, opImm));
      emit(encI(-12'sd5, 0, 3'b000, 1, opImm));
      emit(encI(12'd7, 0, 3'b000, 2, opImm));
      // Register ALU operations, each result stored as a word
      emit(encR(alt, 2, 1, 3'b000, 3));
      emit(encS(12'd0, 3, 10, 3'b010));
      emit(encR(7'd0, 2, 1, 3'b010, 4));
      emit(encS(12'd4, 4, 10, 3'b010));
      emit(encR(7'd0, 2, 1, 3'b011, 5));
      emit(encS(12'd8, 5, 10, 3'b010));
      emit(encR(7'd0, 2, 1, 3'b100, 6));
      emit(encS(12'd12, 6, 10, 3'b010));
      emit(encR(7'd0, 2, 1, 3'b110, 7));
      emit(encS(12'd16, 7, 10, 3'b010));
      emit(encR(7'd0, 2, 1, 3'b111, 8));
      emit(encS(12'd20, 8, 10, 3'b010));
      // Shifts by 31 and by 0
      emit(encI(12'd31, 0, 3'b000, 9, opImm));
      emit(encR(7'd0, 9, 2, 3'b001, 11));
      emit(encS(12'd24, 11, 10, 3'b010));
      emit(encR(7'd0, 9, 1, 3'b101, 12));
      emit(encS(12'd28, 12, 10, 3'b010));
      emit(encR(alt, 9, 1, 3'b101, 13));
      emit(encS(12'd32, 13, 10, 3'b010));
      emit(encR(alt, 0, 1, 3'b101, 14));
      emit(encS(12'd36, 14, 10, 3'b010));
      // Upper immediates, AUIPC sits at byte address 0x68
      emit({20'h12345, 5'd15, opLuiC});
      emit(encS(12'd40, 15, 10, 3'b010));
      emit({20'h00001, 5'd16, opAuiC});
      emit(encS(12'd44, 16, 10, 3'b010));
      // Pattern word for the partial stores and the loads
      emit({20'ha1b2c, 5'd17, opLuiC});
      emit(encI(12'h3d4, 17, 3'b000, 17, opImm));
      emit(encS(12'd48, 17, 10, 3'b000));
      emit(encS(12'd49, 17, 10, 3'b000));
      emit(encS(12'd50, 17, 10, 3'b000));
      emit(encS(12'd51, 17, 10, 3'b000));
      emit(encS(12'd52, 17, 10, 3'b001));
      emit(encS(12'd54, 17, 10, 3'b001));
      emit(encS(12'd56, 17, 10, 3'b010));
      // Loads of the known word, each written back
      emit(encI(12'd56, 10, 3'b000, 18, opLd));
      emit(encS(12'd60, 18, 10, 3'b010));
      emit(encI(12'd57, 10, 3'b100, 19, opLd));
      emit(encS(12'd64, 19, 10, 3'b010));
      emit(encI(12'd58, 10, 3'b001, 20, opLd));
      emit(encS(12'd68, 20, 10, 3'b010));
      emit(encI(12'd56, 10, 3'b101, 21, opLd));
      emit(encS(12'd72, 21, 10, 3'b010));
      emit(encI(12'd56, 10, 3'b010, 22, opLd));
      emit(encS(12'd76, 22, 10, 3'b010));
      // Branches, x1 is -5 and x2 is 7
      emit(encI(12'd0, 0, 3'b000, 23, opImm));
      branchPair(2, 2, 3'b000, 1'b1);
      branchPair(1, 2, 3'b000, 1'b0);
      branchPair(1, 2, 3'b001, 1'b1);
      branchPair(2, 2, 3'b001, 1'b0);
      branchPair(1, 2, 3'b100, 1'b1);
      branchPair(2, 1, 3'b100, 1'b0);
      branchPair(2, 1, 3'b101, 1'b1);
      branchPair(1, 2, 3'b101, 1'b0);
      branchPair(2, 1, 3'b110, 1'b1);
      branchPair(1, 2, 3'b110, 1'b0);
      branchPair(1, 2, 3'b111, 1'b1);
      branchPair(2, 1, 3'b111, 1'b0);
      emit(encS(12'd80, 23, 10, 3'b010));
      // JAL at 0x124 over one poison store
      emit(encJ(21'd8, 24));
      emit(encS(12'h1fc, 1, 10, 3'b010));
      emit(encS(12'd84, 24, 10, 3'b010));
      // AUIPC at 0x130, JALR with odd offset lands on 0x140
      emit({20'h00000, 5'd25, opAuiC});
      emit(encI(12'd17, 25, 3'b000, 26, opJalrC));
      emit(encS(12'h1fc, 1, 10, 3'b010));
      emit(encS(12'h1fc, 1, 10, 3'b010));
      emit(encS(12'd88, 26, 10, 3'b010));
      emit(32'h0010_0073);
   end

   always @(negedge clk) begin
      if (!reset) begin
         rCount    = 0;
         wCount    = 0;
         memRbusy  <= 1'b0;
         memWbusy  <= 1'b0;
         storeSeen <= 1'b0;
      end else begin
         storeSeen <= 1'b0;
         if (rCount > 0) rCount--;
         if (wCount > 0) wCount--;
         // Data is placed at once, busy only delays when the core may take it
         if (memReq.rstrb) begin
            memRdata <= mem[memReq.addr[9:2]];
            rCount = $random(seed) & 3;
         end
         if (memReq.wmask != 4'b0000) begin
            for (int b = 0; b < 4; b++) begin
               if (memReq.wmask[b]) begin
                  mem[memReq.addr[9:2]][8*b +: 8] = memReq.wdata[8*b +: 8];
               end
            end
            storeSeen <= 1'b1;
            storeAddr <= memReq.addr;
            storeMask <= memReq.wmask;
            storeData <= memReq.wdata;
            wCount = $random(seed) & 3;
         end
         memRbusy <= (rCount != 0);
         memWbusy <= (wCount != 0);
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/rvPkg.sv
logic/rvDecoder.sv
logic/rvRegFile.sv
logic/rvAlu.sv
logic/rvLoadStore.sv
logic/rvControl.sv
logic/femtoCore.sv
testbench/tbMemory.sv
testbench/coreTb.sv
